/* common/ej32_pkg.sv */
// shared widths, opcode set and per-opcode decode for the ej32 load/store core
// used by scoped names from every rtl module

package ej32_pkg;

    localparam int dsz = 32;            // data stack width
    localparam int asz = 16;            // byte address width

    typedef enum logic [4:0] {
        op_push, op_dup, op_drop,       // stack ops
        op_iadd, op_isub, op_iand, op_ior, op_ixor,
        op_iaload, op_baload, op_saload,
        op_iastore, op_bastore, op_sastore,
        op_get, op_put                  // console buffers
    } opcode_t;

    typedef enum logic [1:0] {
        eff_none,                       // depth unchanged
        eff_push,
        eff_pop1,
        eff_pop2
    } stack_eff_t;

    // depth change applied when the opcode ends
    function automatic stack_eff_t stack_eff(opcode_t op);
        case (op)
            op_push, op_dup, op_get:              return eff_push;
            op_iaload, op_baload, op_saload:      return eff_none;
            op_iastore, op_bastore, op_sastore:   return eff_pop2;
            default:                              return eff_pop1;  // binops, drop, put
        endcase
    endfunction

    // busy cycles per opcode
    function automatic logic [2:0] phase_count(opcode_t op);
        case (op)
            op_iaload, op_iastore:                return 3'd5;  // 4 bytes + address
            op_saload, op_sastore:                return 3'd3;
            op_baload, op_bastore, op_get, op_put: return 3'd2;
            default:                              return 3'd1;
        endcase
    endfunction

endpackage

/* logic/ej32_seq.sv */
// opcode sequencer: latches a command on go, steps its phases
// and frames it with busy, last and a one-cycle done

module ej32_seq (
    input  logic               ctl,
    input  logic               rst_n,
    input  logic               go,        // sampled while idle only
    input  ej32_pkg::opcode_t  cmd_code,
    output logic               busy,
    output logic               done,
    output logic               last,
    output ej32_pkg::opcode_t  code,
    output logic [2:0]         phase
);

    logic [2:0] n_ph;                     // phases of current opcode

    assign n_ph = ej32_pkg::phase_count(code);
    assign last = busy && (phase == n_ph - 3'd1);   // final phase marker

    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            phase <= 3'd0;
            code  <= ej32_pkg::op_push;
        end
        else begin
            done <= 1'b0;                 // pulse by default
            if (!busy) begin
                if (go) begin             // accept new command
                    busy  <= 1'b1;
                    code  <= cmd_code;
                    phase <= 3'd0;
                end
            end
            else if (last) begin          // opcode ends on this edge
                busy  <= 1'b0;
                done  <= 1'b1;
                phase <= 3'd0;
            end
            else begin
                phase <= phase + 3'd1;
            end
        end
    end

endmodule

/* ls/ej32_ls.sv */
// load/store unit: big-endian int/short/byte moves between the stack and byte memory,
// plus the console input and output buffer pointers

module ej32_ls #(
    parameter logic [ej32_pkg::asz-1:0] tib       = 'h0800,  // input buffer base
    parameter logic [ej32_pkg::asz-1:0] obuf_base = 'h0c00   // output buffer base
) (
    input  logic                      ctl,
    input  logic                      rst_n,
    input  logic                      busy,
    input  ej32_pkg::opcode_t         code,
    input  logic [2:0]                phase,
    input  logic [ej32_pkg::dsz-1:0]  t,          // TOS
    input  logic [ej32_pkg::dsz-1:0]  s,          // NOS
    output logic [ej32_pkg::dsz-1:0]  ls_t,       // TOS candidate
    output logic                      ls_t_x,
    output logic [ej32_pkg::asz-1:0]  mem_addr,
    output logic                      mem_we,
    output logic [7:0]                mem_wdata,
    input  logic [7:0]                mem_rdata   // one cycle after address
);

    logic [ej32_pkg::asz-1:0] a;                  // address register
    logic [1:0]               dsel;               // store byte select, 0 is msb
    logic [ej32_pkg::asz-1:0] ibuf, obuf;         // console pointers

    logic [ej32_pkg::dsz-1:0] t_n;
    logic                     t_x;
    logic [ej32_pkg::asz-1:0] a_n;
    logic                     a_x;
    logic [1:0]               dsel_n;
    logic                     dsel_x;
    logic                     ibuf_x, obuf_x;     // pointer bumps

    logic [ej32_pkg::asz-1:0] t2a, s2a;           // stack words as addresses
    logic [ej32_pkg::dsz-1:0] d2t;                // zero-extended byte
    logic [ej32_pkg::dsz-1:0] t_d;                // byte shifted into TOS

    assign t2a = t[ej32_pkg::asz-1:0];
    assign s2a = s[ej32_pkg::asz-1:0];
    assign d2t = {{(ej32_pkg::dsz-8){1'b0}}, mem_rdata};
    assign t_d = {t[ej32_pkg::dsz-9:0], mem_rdata};   // big-endian merge

    assign ls_t      = t_n;
    assign ls_t_x    = t_x;
    assign mem_addr  = mem_we ? a : a_n;          // reads lead the register by a cycle
    assign mem_wdata = t[{~dsel, 3'b000} +: 8];   // dsel 0 picks t[31:24]

    task set_tos(input logic [ej32_pkg::dsz-1:0] d);
        t_n = d;
        t_x = 1'b1;
    endtask

    task mem_rd(input logic [ej32_pkg::asz-1:0] ad);  // data back next phase
        a_n = ad;
        a_x = 1'b1;
    endtask

    task byte_wr(input logic [1:0] nxt);          // write byte dsel, then select nxt
        mem_we = 1'b1;
        dsel_n = nxt;
        dsel_x = 1'b1;
    endtask

    always_comb begin
        t_n    = t;
        t_x    = 1'b0;
        a_n    = a;
        a_x    = 1'b0;
        dsel_n = dsel;
        dsel_x = 1'b0;
        mem_we = 1'b0;
        ibuf_x = 1'b0;
        obuf_x = 1'b0;
        if (busy) begin
            case (code)
                ej32_pkg::op_iaload:
                    case (phase)
                        3'd0: mem_rd(t2a);
                        3'd1: begin mem_rd(a + 1'b1); set_tos(d2t); end
                        3'd2, 3'd3: begin mem_rd(a + 1'b1); set_tos(t_d); end
                        3'd4: set_tos(t_d);               // lsb
                        default: ;
                    endcase
                ej32_pkg::op_saload:
                    case (phase)
                        3'd0: mem_rd(t2a);
                        3'd1: begin mem_rd(a + 1'b1); set_tos(d2t); end
                        3'd2: set_tos(t_d);
                        default: ;
                    endcase
                ej32_pkg::op_baload:
                    if (phase == 3'd0) mem_rd(t2a);
                    else set_tos(d2t);
                ej32_pkg::op_iastore:
                    case (phase)
                        3'd0: begin mem_rd(s2a); dsel_n = 2'd0; dsel_x = 1'b1; end
                        3'd1: begin mem_rd(a + 1'b1); byte_wr(2'd1); end
                        3'd2: begin mem_rd(a + 1'b1); byte_wr(2'd2); end
                        3'd3: begin mem_rd(a + 1'b1); byte_wr(2'd3); end
                        3'd4: byte_wr(2'd3);
                        default: ;
                    endcase
                ej32_pkg::op_sastore:
                    case (phase)
                        3'd0: begin mem_rd(s2a); dsel_n = 2'd2; dsel_x = 1'b1; end
                        3'd1: begin mem_rd(a + 1'b1); byte_wr(2'd3); end
                        3'd2: byte_wr(2'd3);
                        default: ;
                    endcase
                ej32_pkg::op_bastore:
                    if (phase == 3'd0) begin
                        mem_rd(s2a);
                        dsel_n = 2'd3;                // low byte only
                        dsel_x = 1'b1;
                    end
                    else byte_wr(2'd3);
                ej32_pkg::op_get:
                    if (phase == 3'd0) mem_rd(ibuf);
                    else begin
                        set_tos(d2t);
                        ibuf_x = 1'b1;
                    end
                ej32_pkg::op_put:
                    if (phase == 3'd0) begin
                        mem_rd(obuf);
                        dsel_n = 2'd3;
                        dsel_x = 1'b1;
                    end
                    else begin
                        byte_wr(2'd3);
                        set_tos(s);                   // pop, NOS moves up
                        obuf_x = 1'b1;
                    end
                default: ;                            // alu opcodes
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            a    <= '0;
            dsel <= 2'd3;
            ibuf <= tib;
            obuf <= obuf_base;
        end
        else if (busy) begin
            if (a_x)    a    <= a_n;
            if (dsel_x) dsel <= dsel_n;
            if (ibuf_x) ibuf <= ibuf + 1'b1;
            if (obuf_x) obuf <= obuf + 1'b1;
        end
    end

endmodule

/* logic/ej32_alu.sv */
// arithmetic unit: new TOS for push, dup, drop and the integer binops
// all of its opcodes finish in one phase

module ej32_alu (
    input  ej32_pkg::opcode_t         code,
    input  logic                      busy,
    input  logic [ej32_pkg::dsz-1:0]  t,
    input  logic [ej32_pkg::dsz-1:0]  s,
    input  logic [ej32_pkg::dsz-1:0]  cmd_data,   // push literal
    output logic [ej32_pkg::dsz-1:0]  alu_t,
    output logic                      alu_t_x
);

    logic own;                          // opcode belongs to this unit

    always_comb begin
        alu_t = t;
        own   = 1'b1;
        case (code)
            ej32_pkg::op_push: alu_t = cmd_data;
            ej32_pkg::op_dup:  alu_t = t;        // NOS gets the copy
            ej32_pkg::op_drop: alu_t = s;
            ej32_pkg::op_iadd: alu_t = s + t;    // wraps
            ej32_pkg::op_isub: alu_t = s - t;
            ej32_pkg::op_iand: alu_t = s & t;
            ej32_pkg::op_ior:  alu_t = s | t;
            ej32_pkg::op_ixor: alu_t = s ^ t;
            default:           own   = 1'b0;     // load/store side
        endcase
    end

    assign alu_t_x = busy && own;

endmodule

/* logic/ej32_dstack.sv */
// data stack: TOS and NOS registers over a deeper array
// merges the unit TOS updates and applies the stack effect on the last phase

module ej32_dstack #(
    parameter int depth = 16                      // total entries
) (
    input  logic                      ctl,
    input  logic                      rst_n,
    input  logic                      busy,
    input  logic                      last,
    input  ej32_pkg::opcode_t         code,
    input  logic [ej32_pkg::dsz-1:0]  ls_t,
    input  logic                      ls_t_x,
    input  logic [ej32_pkg::dsz-1:0]  alu_t,
    input  logic                      alu_t_x,
    output logic [ej32_pkg::dsz-1:0]  t,          // TOS
    output logic [ej32_pkg::dsz-1:0]  s,          // NOS
    output logic [$clog2(depth):0]    sp          // depth count
);

    localparam int pw = $clog2(depth);

    logic [ej32_pkg::dsz-1:0] deep [depth];       // spilled entries, slot per depth
    logic [pw-1:0]            ix, ix_m1, ix_m2;
    logic [ej32_pkg::dsz-1:0] t_n;
    ej32_pkg::stack_eff_t     eff;
    logic                     spill;              // NOS pushed into the array

    assign eff   = ej32_pkg::stack_eff(code);
    assign ix    = sp[pw-1:0];
    assign ix_m1 = ix - 1'b1;
    assign ix_m2 = ix - 2'd2;
    assign spill = busy && last && (eff == ej32_pkg::eff_push);

    // units never claim TOS together
    always_comb begin
        if (ls_t_x)       t_n = ls_t;
        else if (alu_t_x) t_n = alu_t;
        else              t_n = t;
    end

    always_ff @(posedge ctl) begin
        if (!rst_n) begin
            t  <= '0;
            s  <= '0;
            sp <= '0;
        end
        else if (busy) begin
            t <= t_n;
            if (last) begin
                case (eff)
                    ej32_pkg::eff_push: begin
                        s  <= t;                  // old TOS slides down
                        sp <= sp + 1'b1;
                    end
                    ej32_pkg::eff_pop1: begin
                        s  <= deep[ix_m1];
                        sp <= sp - 1'b1;
                    end
                    ej32_pkg::eff_pop2: begin     // both refill, unit TOS dropped
                        t  <= deep[ix_m1];
                        s  <= deep[ix_m2];
                        sp <= sp - 2'd2;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (spill) deep[ix] <= s;
    end

endmodule

/* logic/ej32_ram.sv */
// byte memory for the load/store unit, one-cycle registered read
// a write in the same cycle is returned on rdata

module ej32_ram #(
    parameter int mem_aw = 12                     // decoded address bits
) (
    input  logic                      ctl,
    input  logic [ej32_pkg::asz-1:0]  addr,       // upper bits not decoded
    input  logic                      we,
    input  logic [7:0]                wdata,
    output logic [7:0]                rdata
);

    logic [7:0] mem [2**mem_aw];

    always_ff @(posedge ctl) begin
        if (we) begin
            mem[addr[mem_aw-1:0]] <= wdata;
            rdata                 <= wdata;       // write-first
        end
        else begin
            rdata <= mem[addr[mem_aw-1:0]];
        end
    end

endmodule

/* logic/ej32_top.sv */
// ej32 load/store core top: sequencer, load/store and arithmetic units,
// data stack and byte memory; the host drives one opcode per go pulse

module ej32_top #(
    parameter logic [ej32_pkg::asz-1:0] tib       = 'h0800,
    parameter logic [ej32_pkg::asz-1:0] obuf_base = 'h0c00,
    parameter int                       mem_aw    = 12,
    parameter int                       depth     = 16
) (
    input  logic                      ctl,
    input  logic                      rst_n,
    input  logic                      go,
    input  ej32_pkg::opcode_t         cmd_code,
    input  logic [ej32_pkg::dsz-1:0]  cmd_data,
    output logic                      busy,
    output logic                      done,
    output logic [ej32_pkg::dsz-1:0]  tos,
    output logic [ej32_pkg::dsz-1:0]  nos,
    output logic [$clog2(depth):0]    sp
);

    ej32_pkg::opcode_t        code;
    logic [2:0]               phase;
    logic                     last;
    logic [ej32_pkg::dsz-1:0] ls_t, alu_t;        // TOS candidates
    logic                     ls_t_x, alu_t_x;
    logic [ej32_pkg::asz-1:0] mem_addr;
    logic                     mem_we;
    logic [7:0]               mem_wdata, mem_rdata;

    ej32_seq seq_i (
        .ctl(ctl), .rst_n(rst_n), .go(go), .cmd_code(cmd_code),
        .busy(busy), .done(done), .last(last), .code(code), .phase(phase)
    );

    ej32_ls #(.tib(tib), .obuf_base(obuf_base)) ls_i (
        .ctl(ctl), .rst_n(rst_n), .busy(busy), .code(code), .phase(phase),
        .t(tos), .s(nos), .ls_t(ls_t), .ls_t_x(ls_t_x),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    ej32_alu alu_i (
        .code(code), .busy(busy), .t(tos), .s(nos), .cmd_data(cmd_data),
        .alu_t(alu_t), .alu_t_x(alu_t_x)
    );

    ej32_dstack #(.depth(depth)) dstack_i (
        .ctl(ctl), .rst_n(rst_n), .busy(busy), .last(last), .code(code),
        .ls_t(ls_t), .ls_t_x(ls_t_x), .alu_t(alu_t), .alu_t_x(alu_t_x),
        .t(tos), .s(nos), .sp(sp)
    );

    ej32_ram #(.mem_aw(mem_aw)) ram_i (
        .ctl(ctl), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

endmodule

/* testbench/tb_ej32.sv */
// issues opcodes to the ej32 load/store core one go at a time
// and checks tos, nos and sp against a stack and byte memory model on every done

module tb_ej32;

    localparam logic [15:0] tib_a  = 16'h0800;    // top defaults
    localparam logic [15:0] obuf_a = 16'h0c00;
    localparam int          n_cmds = 170;         // upper bound on commands issued
    localparam int          t_max  = n_cmds * 8 * 10 * 2 + 100;

    logic              ctl;
    logic              rst_n;
    logic              go;
    ej32_pkg::opcode_t cmd_code;
    logic [31:0]       cmd_data;
    logic              busy;
    logic              done;
    logic [31:0]       tos, nos;
    logic [4:0]        sp;

    logic [31:0]       q [$];                     // model stack, bottom first
    logic [7:0]        mem_m [4096];              // model memory, 12 address bits
    logic [15:0]       ip_m, op_m;                // model buffer pointers
    logic [31:0]       exp_tos, exp_nos;
    logic [4:0]        exp_sp;
    ej32_pkg::opcode_t stack_ops [8];             // random pool for stack tests
    int                errs     = 0;
    int                n_issued = 0;
    int                n_done   = 0;
    int                n_tests  = 0;

    ej32_top dut_i (
        .ctl(ctl), .rst_n(rst_n), .go(go), .cmd_code(cmd_code), .cmd_data(cmd_data),
        .busy(busy), .done(done), .tos(tos), .nos(nos), .sp(sp)
    );

    initial ctl = 1'b0;
    always #5 ctl = ~ctl;

    // outputs settle well before the falling edge
    result_chk: assert property (@(negedge ctl) disable iff (!rst_n)
        done |-> (tos == exp_tos && nos == exp_nos && sp == exp_sp))
        else begin
            errs = errs + 1;
            $display("ERR %0t: tos %h nos %h sp %0d, model %h %h %0d",
                     $time, tos, nos, sp, exp_tos, exp_nos, exp_sp);
        end

    pulse_chk: assert property (@(negedge ctl) disable iff (!rst_n) done |=> !done)
        else begin
            errs = errs + 1;
            $display("ERR %0t: done high for more than one cycle", $time);
        end

    always @(negedge ctl) begin
        if (rst_n && done) n_done <= n_done + 1;  // every done pulse seen
    end

    function automatic int exp_phases(input ej32_pkg::opcode_t c);
        case (c)
            ej32_pkg::op_iaload, ej32_pkg::op_iastore: return 5;
            ej32_pkg::op_saload, ej32_pkg::op_sastore: return 3;
            ej32_pkg::op_baload, ej32_pkg::op_bastore,
            ej32_pkg::op_get, ej32_pkg::op_put:       return 2;
            default:                                  return 1;
        endcase
    endfunction

    // big-endian read with the first byte most significant
    function automatic logic [31:0] rd_be(input logic [15:0] ad, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[23:0], mem_m[12'(ad + 16'(i))]};
        end
        return r;
    endfunction

    task automatic wr_be(input logic [15:0] ad, input logic [31:0] v, input int n);
        for (int i = 0; i < n; i++) begin
            mem_m[12'(ad + 16'(i))] = v[8*(n-1-i) +: 8];   // msb at lowest address
        end
    endtask

    task automatic apply_model(input ej32_pkg::opcode_t c, input logic [31:0] d);
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        n = (c == ej32_pkg::op_iaload || c == ej32_pkg::op_iastore) ? 4 :
            (c == ej32_pkg::op_saload || c == ej32_pkg::op_sastore) ? 2 : 1;
        case (c)
            ej32_pkg::op_push: q.push_back(d);
            ej32_pkg::op_dup:  q.push_back(q[$]);
            ej32_pkg::op_drop: void'(q.pop_back());
            ej32_pkg::op_iaload, ej32_pkg::op_saload, ej32_pkg::op_baload: begin
                a = q.pop_back();                 // address replaced by data
                q.push_back(rd_be(a[15:0], n));
            end
            ej32_pkg::op_iastore, ej32_pkg::op_sastore, ej32_pkg::op_bastore: begin
                b = q.pop_back();                 // value on TOS
                a = q.pop_back();                 // address on NOS
                wr_be(a[15:0], b, n);
            end
            ej32_pkg::op_get: begin
                q.push_back({24'd0, mem_m[ip_m[11:0]]});
                ip_m = ip_m + 16'd1;
            end
            ej32_pkg::op_put: begin
                b = q.pop_back();
                mem_m[op_m[11:0]] = b[7:0];       // low byte only
                op_m = op_m + 16'd1;
            end
            default: begin
                b = q.pop_back();                 // right operand
                a = q.pop_back();
                case (c)
                    ej32_pkg::op_iadd: q.push_back(a + b);
                    ej32_pkg::op_isub: q.push_back(a - b);
                    ej32_pkg::op_iand: q.push_back(a & b);
                    ej32_pkg::op_ior:  q.push_back(a | b);
                    default:           q.push_back(a ^ b);
                endcase
            end
        endcase
        exp_tos = q[$];
        exp_nos = q[$-1];
        exp_sp  = 5'(q.size() - 2);               // two registers below the count
    endtask

    task automatic run_op(input ej32_pkg::opcode_t c, input logic [31:0] d, input bit stray);
        int nbusy;
        int cyc;
        nbusy = 0;
        cyc   = 0;
        @(posedge ctl);
        go       <= 1'b1;
        cmd_code <= c;
        cmd_data <= d;
        n_issued++;
        @(negedge ctl);
        apply_model(c, d);                        // ready long before done
        forever begin
            @(posedge ctl);
            go <= stray && nbusy == 2;            // extra pulse mid-command
            if (stray && nbusy == 2) begin
                cmd_code <= ej32_pkg::op_push;
                cmd_data <= $urandom;
            end
            @(negedge ctl);
            cyc++;
            if (done) break;
            if (busy) nbusy++;
            if (cyc > 20) begin
                errs++;
                $display("command %s never signalled done", c.name());
                break;
            end
        end
        // done follows the go edge by phase count plus one edges
        busy_len: assert (nbusy == exp_phases(c) && cyc == exp_phases(c) + 1)
            else begin
                errs++;
                $display("ERR %0t: %s busy %0d cycles, done on edge %0d, expected %0d and %0d",
                         $time, c.name(), nbusy, cyc, exp_phases(c), exp_phases(c) + 1);
            end
    endtask

    task automatic store_val(input ej32_pkg::opcode_t c, input logic [15:0] ad,
                             input logic [31:0] v, input bit stray);
        run_op(ej32_pkg::op_push, {16'd0, ad}, 1'b0);
        run_op(ej32_pkg::op_push, v, 1'b0);
        run_op(c, 32'd0, stray);
    endtask

    task automatic load_check(input ej32_pkg::opcode_t c, input logic [15:0] ad,
                              input bit stray);
        run_op(ej32_pkg::op_push, {16'd0, ad}, 1'b0);
        run_op(c, 32'd0, stray);                  // loaded word checked on done
        run_op(ej32_pkg::op_drop, 32'd0, 1'b0);
    endtask

    task automatic drain_stack;
        while (q.size() > 2) begin
            run_op(ej32_pkg::op_drop, 32'd0, 1'b0);
        end
    endtask

    task automatic random_ops(input int n);
        int k;
        int cur;
        for (int i = 0; i < n; i++) begin
            cur = q.size() - 2;
            if (cur < 2) k = int'($urandom_range(1, 0));          // grow only
            else if (cur >= 12) k = int'($urandom_range(7, 2));   // shrink only
            else k = int'($urandom_range(7, 0));
            run_op(stack_ops[k], $urandom, 1'b0);
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %0d %s finished, %0d errors so far", n_tests, name, errs);
    endtask

    initial begin
        #(t_max);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [15:0] ad;
        void'($urandom(61775));
        rst_n     = 1'b0;
        go        = 1'b0;
        cmd_code  = ej32_pkg::op_push;
        cmd_data  = '0;
        q.push_back(32'd0);                       // NOS and TOS clear after reset
        q.push_back(32'd0);
        ip_m      = tib_a;
        op_m      = obuf_a;
        exp_tos   = '0;
        exp_nos   = '0;
        exp_sp    = '0;
        stack_ops = '{ej32_pkg::op_push, ej32_pkg::op_dup, ej32_pkg::op_drop,
                      ej32_pkg::op_iadd, ej32_pkg::op_isub, ej32_pkg::op_iand,
                      ej32_pkg::op_ior, ej32_pkg::op_ixor};
        repeat (3) @(posedge ctl);
        rst_n <= 1'b1;
        @(negedge ctl);
        reset_clear: assert (!busy && !done && sp == 5'd0 && tos == '0 && nos == '0)
            else begin
                errs++;
                $display("ERR %0t: outputs not clear after reset", $time);
            end
        run_op(ej32_pkg::op_push, $urandom, 1'b0);
        run_op(ej32_pkg::op_dup, 32'd0, 1'b0);
        run_op(ej32_pkg::op_drop, 32'd0, 1'b0);
        end_test("reset and handshake");

        random_ops(40);
        drain_stack();
        end_test("random stack ops");

        for (int r = 0; r < 2; r++) begin
            w  = $urandom;
            ad = 16'($urandom_range(16'h07f0));   // below the console buffers
            store_val(ej32_pkg::op_iastore, ad, w, 1'b0);
            load_check(ej32_pkg::op_iaload, ad, 1'b0);
            for (int k = 0; k < 4; k++) load_check(ej32_pkg::op_baload, ad + 16'(k), 1'b0);
            for (int k = 0; k < 2; k++) load_check(ej32_pkg::op_saload, ad + 16'(2*k), 1'b0);
        end
        end_test("word, short and byte loads");

        ad = 16'($urandom_range(16'h07f0));
        store_val(ej32_pkg::op_iastore, ad, $urandom, 1'b0);
        store_val(ej32_pkg::op_bastore, ad + 16'd1, $urandom, 1'b0);
        load_check(ej32_pkg::op_iaload, ad, 1'b0);
        store_val(ej32_pkg::op_sastore, ad + 16'd2, $urandom, 1'b0);
        load_check(ej32_pkg::op_iaload, ad, 1'b0);
        end_test("partial stores");

        for (int k = 0; k < 4; k++) begin
            store_val(ej32_pkg::op_bastore, tib_a + 16'(k), $urandom, 1'b0);
        end
        for (int k = 0; k < 4; k++) run_op(ej32_pkg::op_get, 32'd0, 1'b0);
        drain_stack();
        for (int k = 0; k < 4; k++) begin
            run_op(ej32_pkg::op_push, $urandom, 1'b0);
            run_op(ej32_pkg::op_put, 32'd0, 1'b0);
        end
        for (int k = 0; k < 4; k++) load_check(ej32_pkg::op_baload, obuf_a + 16'(k), 1'b0);
        end_test("console get and put");

        ad = 16'($urandom_range(16'h07f0));
        store_val(ej32_pkg::op_iastore, ad, $urandom, 1'b1);
        load_check(ej32_pkg::op_iaload, ad, 1'b1);
        @(posedge ctl);                           // last done counted by now
        done_count: assert (n_done == n_issued)
            else begin
                errs++;
                $display("ERR %0t: %0d done pulses for %0d commands", $time, n_done, n_issued);
            end
        end_test("go while busy");

        $display("%0d tests, %0d commands, %0d errors", n_tests, n_issued, errs);
        if (errs == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
common/ej32_pkg.sv
logic/ej32_seq.sv
ls/ej32_ls.sv
logic/ej32_alu.sv
logic/ej32_dstack.sv
logic/ej32_ram.sv
logic/ej32_top.sv
testbench/tb_ej32.sv

/* run.sh */
#!/usr/bin/env bash
# builds the ej32 testbench with Verilator, runs it and checks the result line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ej32 -f sim.f \
    && out="$(./obj_dir/Vtb_ej32)" \
    || { echo "build or simulation run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Finished with no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
